// File: sources.f
verilog/dmm_pkg.sv
verilog/spi_slave.sv
verilog/register_bank.sv
verilog/adc_mock.sv
verilog/seq_controller.sv
verilog/mode_mux.sv
verilog/dmm_top.sv
bench/tb_clock.sv
bench/dmm_sva.sv
bench/tb_dmm.sv

// File: run.sh
#!/bin/sh
# compile and run the dmm testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_dmm -o tb_dmm
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dmm > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ] || grep -q "RESULT: FAIL" "$LOG" || ! grep -q "RESULT: PASS" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0

// File: bench/tb_dmm.sv
`timescale 1ns/1ns

module tb_dmm import dmm_pkg::*; ();

  localparam int          COUNT_W   = 16;
  localparam int          HALF_SCK  = 8;      // clk cycles per sck level
  localparam int          PRE_VAL   = 5;
  localparam int          APER_VAL  = 7;
  localparam int          SEQ_N_VAL = 2;
  localparam logic [3:0]  FLAGS     = 4'hd;
  localparam logic [31:0] STATUS_EXP = {18'b0, 2'b00, FLAGS, 8'hAA};

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINS, OP_PATTERN, OP_AZ_RUN, OP_AZ_STOP} op_t;

  typedef struct packed {
    op_t         op;
    reg_addr_t   addr;
    logic [31:0] data;     // write data or op argument
    logic [31:0] exp_val;
  } row_t;

  logic clk, reset;
  logic sck, ss, sdi, trigger, sdo;
  logic [3:0] hw_flags;
  logic [3:0] leds;
  logic [7:0] monitor;
  logic [3:0] azmux;
  logic [1:0] pc_sw;
  logic meas_complete;
  logic [18:0] pins;        // same layout as out_word_t

  row_t       rows[$];
  logic [5:0] seq_val [4];
  int         seed = 32'hfef7_a83b;
  logic       table_ready = 1'b0;

  assign pins = {meas_complete, azmux, pc_sw, monitor, leds};

  tb_clock u_clk (.clk_o(clk), .reset_o(reset));

  dmm_top #(.COUNT_W(COUNT_W)) UUT (
    .CLK(clk), .reset_i(reset),
    .sck_i(sck), .ss_i(ss), .sdi_i(sdi), .sdo_o(sdo),
    .trigger_i(trigger), .hw_flags_i(hw_flags),
    .leds_o(leds), .monitor_o(monitor), .azmux_o(azmux),
    .pc_sw_o(pc_sw), .meas_complete_o(meas_complete)
  );

  //////////////////////////////////////////////////
  // helpers

  task automatic step_clks(input int n);
    repeat (n) @(posedge clk);
    #2;                                  // drive and sample off the edge
  endtask

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp_val);
    assert (got === exp_val)
      else report_and_stop($sformatf("ERROR: %s got %h expected %h", name, got, exp_val));
  endtask

  // one 40 bit frame, mode 0, msb first
  task automatic spi_frame(input logic wr, input reg_addr_t addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    ss = 1'b0;
    step_clks(HALF_SCK);
    for (int i = 39; i >= 0; i--) begin
      sdi = frame[i];
      step_clks(HALF_SCK);
      sck = 1'b1;
      if (i < 32) rdata = {rdata[30:0], sdo};  // host samples on the rising edge
      step_clks(HALF_SCK);
      sck = 1'b0;
    end
    step_clks(HALF_SCK);
    ss = 1'b1;
    step_clks(HALF_SCK);
  endtask

  function automatic logic [31:0] mask_for(input reg_addr_t addr);
    case (addr)
      ADDR_MODE:                                   return 32'h7;
      ADDR_DIRECT:                                 return 32'h7_ffff;
      ADDR_SEQ_N:                                  return 32'h3;
      ADDR_SEQ0, ADDR_SEQ1, ADDR_SEQ2, ADDR_SEQ3:  return 32'h3f;
      ADDR_PRECHARGE, ADDR_APERTURE:               return (32'h1 << COUNT_W) - 1;
      default:                                     return 32'h0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // checks that span many cycles

  task automatic check_pattern(input int n);
    logic [18:0] prev;
    prev = pins;
    for (int i = 0; i < n; i++) begin
      step_clks(1);
      check_word("pattern pins", 32'(pins), 32'(prev + 19'd1));  // wraps at 2^19
      prev = pins;
    end
  endtask

  task automatic run_az(input int n_changes);
    logic [5:0] prev;
    logic [5:0] cur;
    int idx, gap, meas_cnt, changes, cycles;
    prev = {pc_sw, azmux};
    idx = 0;
    gap = 0;
    meas_cnt = 0;
    changes = 0;
    cycles = 0;
    trigger = 1'b1;
    while (changes < n_changes) begin
      step_clks(1);
      cycles++;
      gap++;
      if (meas_complete) meas_cnt++;
      cur = {pc_sw, azmux};
      if (cur != prev) begin
        check_word("azmux_o/pc_sw_o", 32'(cur), 32'(seq_val[idx]));
        if (changes > 0)
          assert (gap >= PRE_VAL + APER_VAL + 2)
            else report_and_stop($sformatf("ERROR: step gap got %h expected at least %h",
                                           gap, PRE_VAL + APER_VAL + 2));
        // one end of pass pulse right before the wrap to step 0
        check_word("meas_complete_o pulses", 32'(meas_cnt), (idx == 0 && changes > 0) ? 1 : 0);
        meas_cnt = 0;
        gap = 0;
        changes++;
        idx = (idx == SEQ_N_VAL) ? 0 : idx + 1;
        prev = cur;
      end
      assert (cycles < 4000) else report_and_stop("az sequence stopped advancing");
    end
  endtask

  task automatic stop_az();
    logic [31:0] rd;
    int waited;
    trigger = 1'b0;
    waited = 0;
    while (leds[3] && waited <= PRE_VAL + APER_VAL + 8) begin
      step_clks(1);
      waited++;
    end
    assert (!leds[3]) else report_and_stop("busy led did not fall after trigger dropped");
    for (int i = 0; i < 2 * (PRE_VAL + APER_VAL + 4); i++) begin
      step_clks(1);
      check_word("meas/azmux/pc_sw when stopped", 32'(pins[18:12]), 32'h0);
    end
    spi_frame(1'b0, ADDR_STATUS, 32'h0, rd);
    check_word("status low bits", {20'b0, rd[11:0]}, {20'b0, FLAGS, 8'hAA});
    assert (rd[13:12] <= SEQ_N_VAL)
      else report_and_stop($sformatf("ERROR: status step got %h beyond seq_n %h",
                                     rd[13:12], SEQ_N_VAL));
  endtask

  //////////////////////////////////////////////////
  // stimulus table

  task automatic add_row(input op_t op, input reg_addr_t addr,
                         input logic [31:0] data, input logic [31:0] exp_val);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.data    = data;
    r.exp_val = exp_val;
    rows.push_back(r);
  endtask

  task automatic build_table();
    reg_addr_t   rw_addr [9];
    logic [31:0] rnd [9];
    logic [31:0] d;
    int          modes [5];
    rw_addr = '{ADDR_MODE, ADDR_DIRECT, ADDR_SEQ_N, ADDR_SEQ0, ADDR_SEQ1,
                ADDR_SEQ2, ADDR_SEQ3, ADDR_PRECHARGE, ADDR_APERTURE};
    modes   = '{1, 2, 5, 6, 7};
    seq_val = '{6'h15, 6'h2a, 6'h3c, 6'h07};
    add_row(OP_PINS, 7'd0, 32'h0, 32'h0);             // all pins low after reset
    add_row(OP_RD, ADDR_STATUS, 32'h0, STATUS_EXP);
    foreach (rw_addr[i]) begin
      rnd[i] = $random(seed);
      add_row(OP_WR, rw_addr[i], rnd[i], 32'h0);
    end
    foreach (rw_addr[i])
      add_row(OP_RD, rw_addr[i], 32'h0, rnd[i] & mask_for(rw_addr[i]));
    // read only and unmapped addresses
    add_row(OP_WR, ADDR_STATUS, $random(seed), 32'h0);
    add_row(OP_RD, ADDR_STATUS, 32'h0, STATUS_EXP);
    add_row(OP_WR, 7'h55, $random(seed), 32'h0);
    add_row(OP_RD, 7'h55, 32'h0, 32'h0);
    add_row(OP_RD, ADDR_MODE, 32'h0, rnd[0] & 32'h7);
    // direct and fixed level modes
    d = $random(seed);
    add_row(OP_WR, ADDR_DIRECT, d, 32'h0);
    add_row(OP_WR, ADDR_MODE, 32'd0, 32'h0);
    add_row(OP_PINS, 7'd0, 32'h0, d & 32'h7_ffff);
    foreach (modes[i]) begin
      add_row(OP_WR, ADDR_MODE, modes[i], 32'h0);
      add_row(OP_PINS, 7'd0, 32'h0, (modes[i] == 2) ? 32'h7_ffff : 32'h0);
    end
    add_row(OP_WR, ADDR_MODE, 32'd0, 32'h0);
    add_row(OP_PINS, 7'd0, 32'h0, d & 32'h7_ffff);
    add_row(OP_WR, ADDR_MODE, 32'd3, 32'h0);
    add_row(OP_PATTERN, 7'd0, 32'd32, 32'h0);         // 32 consecutive samples
    // az test sequence over steps 0..2
    add_row(OP_WR, ADDR_SEQ_N, SEQ_N_VAL, 32'h0);
    foreach (seq_val[i])
      add_row(OP_WR, ADDR_SEQ0 + reg_addr_t'(i), 32'(seq_val[i]), 32'h0);
    add_row(OP_WR, ADDR_PRECHARGE, PRE_VAL, 32'h0);
    add_row(OP_WR, ADDR_APERTURE, APER_VAL, 32'h0);
    add_row(OP_WR, ADDR_MODE, 32'd4, 32'h0);
    add_row(OP_AZ_RUN, 7'd0, 32'd7, 32'h0);           // two passes plus wrap
    add_row(OP_AZ_STOP, 7'd0, 32'h0, 32'h0);
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] rd;
    case (r.op)
      OP_WR:      spi_frame(1'b1, r.addr, r.data, rd);
      OP_RD: begin
        spi_frame(1'b0, r.addr, 32'h0, rd);
        check_word($sformatf("rdata[addr %h]", r.addr), rd, r.exp_val);
      end
      OP_PINS: begin
        step_clks(1);
        check_word("pins", 32'(pins), r.exp_val);
      end
      OP_PATTERN: check_pattern(r.data);
      OP_AZ_RUN:  run_az(r.data);
      OP_AZ_STOP: stop_az();
      default:    report_and_stop("unknown operation in stimulus table");
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    sck      = 1'b0;
    ss       = 1'b1;
    sdi      = 1'b0;
    trigger  = 1'b0;
    hw_flags = FLAGS;
    build_table();
    table_ready = 1'b1;
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    step_clks(2);
    foreach (rows[i]) apply_row(rows[i]);
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = rows.size() * 2000 + 20000;
    repeat (limit) @(posedge clk);
    $display("timeout, the test sequence did not finish within %0d clock cycles", limit);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: bench/dmm_sva.sv
`timescale 1ns/1ns

module dmm_sva (
  input logic       clk_i,
  input logic       reset_i,
  input logic [1:0] state_i,      // controller state code
  input logic       adc_reset_i,
  input logic       adc_valid_i,
  input logic       meas_i
);

  localparam logic [1:0] ST_IDLE      = 2'd0;
  localparam logic [1:0] ST_PRECHARGE = 2'd1;

  // adc only leaves reset for the measure phase
  a_adc_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == ST_IDLE || state_i == ST_PRECHARGE) |-> adc_reset_i)
    else $error("adc released while idle or precharging");

  a_no_early_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == ST_PRECHARGE) |-> !adc_valid_i)
    else $error("adc valid seen during precharge");

  // end of pass marker is a single clk
  a_meas_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    meas_i |=> !meas_i)
    else $error("meas_complete high for two cycles");

endmodule

bind seq_controller dmm_sva u_sva (
  .clk_i(CLK), .reset_i(reset_i), .state_i(state_q),
  .adc_reset_i(adc_reset_o), .adc_valid_i(adc_valid_i),
  .meas_i(out_o.meas_complete)
);

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS  = 20,
  parameter int RESET_CLKS = 10
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // sync reset, released just after an edge like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CLKS) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// File: verilog/dmm_top.sv
`timescale 1ns/1ns

module dmm_top import dmm_pkg::*; #(
  parameter int COUNT_W = 24  // precharge / aperture counter width, 8..24
) (
  input  logic       CLK,
  input  logic       reset_i,
  // spi host link
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic       trigger_i,
  input  logic [3:0] hw_flags_i,
  // board outputs
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output azmux_t     azmux_o,
  output pc_sw_t     pc_sw_o,
  output logic       meas_complete_o
);

  reg_access_t acc;
  word_t       rdata;
  mode_t       mode;
  out_word_t   direct;
  acq_cfg_t    cfg;
  step_idx_t   step;
  logic        adc_reset;
  logic        adc_valid;
  out_word_t   az_word;
  out_word_t   pins;
  logic        az_run;

  assign az_run = (mode == MODE_AZ_TEST);  // controller only runs in az test

  //////////////////////////////////////////////////
  // host side

  spi_slave u_spi (
    .CLK(CLK), .reset_i(reset_i),
    .sck_i(sck_i), .ss_i(ss_i), .sdi_i(sdi_i), .sdo_o(sdo_o),
    .acc_o(acc), .rdata_i(rdata)
  );

  register_bank #(.COUNT_W(COUNT_W)) u_regs (
    .CLK(CLK), .reset_i(reset_i),
    .acc_i(acc), .rdata_o(rdata),
    .hw_flags_i(hw_flags_i), .step_i(step),
    .mode_o(mode), .direct_o(direct), .cfg_o(cfg)
  );

  //////////////////////////////////////////////////
  // acquisition with mocked adc

  adc_mock #(.COUNT_W(COUNT_W)) u_adc (
    .CLK(CLK), .reset_i(reset_i),
    .adc_reset_i(adc_reset),
    .aperture_i(cfg.aperture[COUNT_W-1:0]),
    .valid_o(adc_valid)
  );

  seq_controller #(.COUNT_W(COUNT_W)) u_seq (
    .CLK(CLK), .reset_i(reset_i),
    .run_i(az_run), .trigger_i(trigger_i), .cfg_i(cfg),
    .adc_valid_i(adc_valid), .adc_reset_o(adc_reset),
    .out_o(az_word), .step_o(step)
  );

  mode_mux u_mux (
    .CLK(CLK), .reset_i(reset_i),
    .mode_i(mode), .direct_i(direct), .az_i(az_word),
    .out_o(pins)
  );

  // unpack onto the pins
  assign meas_complete_o = pins.meas_complete;
  assign azmux_o         = pins.azmux;
  assign pc_sw_o         = pins.pc_sw;
  assign monitor_o       = pins.monitor;
  assign leds_o          = pins.leds;

endmodule

// File: verilog/mode_mux.sv
`timescale 1ns/1ns

module mode_mux import dmm_pkg::*; (
  input  logic      CLK,
  input  logic      reset_i,
  input  mode_t     mode_i,
  input  out_word_t direct_i,
  input  out_word_t az_i,
  output out_word_t out_o
);

  localparam int OUT_W = $bits(out_word_t);  // 19

  //////////////////////////////////////////////////
  // free running test pattern

  logic [OUT_W-1:0] pat_q;  // wraps at 2^19
  out_word_t        sel;
  out_word_t        out_q;

  // mode select
  always_comb begin
    case (mode_i)
      MODE_DIRECT:  sel = direct_i;
      MODE_LO:      sel = '0;
      MODE_HI:      sel = '1;               // every pin high
      MODE_PATTERN: sel = out_word_t'(pat_q);
      MODE_AZ_TEST: sel = az_i;             // sequence controller with mock adc
      default:      sel = '0;               // spare codes stay low
    endcase
  end

  // one register stage onto the pins
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      pat_q <= '0;
      out_q <= '0;
    end else begin
      pat_q <= pat_q + 1'b1;
      out_q <= sel;
    end
  end

  assign out_o = out_q;

endmodule

// File: verilog/seq_controller.sv
`timescale 1ns/1ns

module seq_controller import dmm_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic      CLK,
  input  logic      reset_i,
  input  logic      run_i,        // az test mode selected
  input  logic      trigger_i,
  input  acq_cfg_t  cfg_i,
  input  logic      adc_valid_i,
  output logic      adc_reset_o,
  output out_word_t out_o,
  output step_idx_t step_o
);

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    PRECHARGE = 2'd1,
    MEASURE   = 2'd2,
    DONE      = 2'd3
  } seq_state_t;

  seq_state_t         state_q;
  step_idx_t          step_q;
  logic [COUNT_W-1:0] cnt_q;       // precharge timer
  azmux_t             azmux_q;
  pc_sw_t             pc_q;
  logic               adc_reset_q;
  logic               meas_q;

  seq_step_t cur_step;
  logic      last_step;

  assign cur_step  = cfg_i.seq[step_q];
  assign last_step = (step_q == cfg_i.seq_n);

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      state_q     <= IDLE;
      step_q      <= '0;
      cnt_q       <= '0;
      azmux_q     <= '0;
      pc_q        <= '0;
      adc_reset_q <= 1'b1;
      meas_q      <= 1'b0;
    end else begin
      meas_q <= 1'b0;
      if (!run_i) begin
        // other modes own the pins, park everything
        state_q     <= IDLE;
        step_q      <= '0;
        azmux_q     <= '0;
        pc_q        <= '0;
        adc_reset_q <= 1'b1;
      end else begin
        case (state_q)
          IDLE: begin
            if (trigger_i) begin
              state_q <= PRECHARGE;
              step_q  <= '0;
              cnt_q   <= '0;
            end
          end
          PRECHARGE: begin
            if (cnt_q == '0) begin
              azmux_q <= azmux_t'(cur_step[3:0]);  // switches move one clk in
              pc_q    <= pc_sw_t'(cur_step[5:4]);
            end
            if (cnt_q == cfg_i.precharge[COUNT_W-1:0]) begin
              state_q     <= MEASURE;
              adc_reset_q <= 1'b0;                 // release adc for one aperture
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          MEASURE: begin
            if (adc_valid_i) begin
              state_q     <= DONE;
              adc_reset_q <= 1'b1;
              meas_q      <= last_step;            // end of pass
            end
          end
          DONE: begin
            cnt_q <= '0;
            if (!trigger_i) begin
              state_q <= IDLE;                     // keep step index for status
              azmux_q <= '0;
              pc_q    <= '0;
            end else begin
              state_q <= PRECHARGE;
              step_q  <= last_step ? step_idx_t'(0) : step_q + 1'b1;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // output bundle

  assign out_o.meas_complete = meas_q;
  assign out_o.azmux         = azmux_q;
  assign out_o.pc_sw         = pc_q;
  assign out_o.monitor       = {4'b0, adc_valid_i, adc_reset_q, state_q};  // state in low bits
  assign out_o.leds          = {state_q != IDLE, 1'b0, step_q};           // busy, step

  assign adc_reset_o = adc_reset_q;
  assign step_o      = step_q;

endmodule

// File: verilog/adc_mock.sv
`timescale 1ns/1ns

module adc_mock import dmm_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic               CLK,
  input  logic               reset_i,
  input  logic               adc_reset_i,  // held high between samples
  input  logic [COUNT_W-1:0] aperture_i,
  output logic               valid_o
);

  logic [COUNT_W-1:0] cnt_q;
  logic               done_q;   // sample delivered, wait for next reset
  logic               valid_q;

  // valid lands aperture+1 clks after adc reset is released
  always_ff @(posedge CLK) begin
    if (reset_i || adc_reset_i) begin
      cnt_q   <= '0;
      done_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!done_q) begin
        if (cnt_q == aperture_i) begin
          valid_q <= 1'b1;   // single pulse
          done_q  <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign valid_o = valid_q;

endmodule

// File: verilog/register_bank.sv
`timescale 1ns/1ns

module register_bank import dmm_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic        CLK,
  input  logic        reset_i,
  input  reg_access_t acc_i,
  output word_t       rdata_o,
  input  logic [3:0]  hw_flags_i,
  input  step_idx_t   step_i,
  output mode_t       mode_o,
  output out_word_t   direct_o,
  output acq_cfg_t    cfg_o
);

  mode_t              mode_q;
  out_word_t          direct_q;
  step_idx_t          seq_n_q;
  seq_step_t [3:0]    seq_q;
  logic [COUNT_W-1:0] precharge_q;
  logic [COUNT_W-1:0] aperture_q;

  logic we;
  assign we = acc_i.strobe & acc_i.write;

  //////////////////////////////////////////////////
  // writes, status and unknown addrs are dropped

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      mode_q      <= MODE_DIRECT;
      direct_q    <= '0;
      seq_n_q     <= '0;
      seq_q       <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
    end else if (we) begin
      case (acc_i.addr)
        ADDR_MODE:      mode_q      <= mode_t'(acc_i.wdata[2:0]);
        ADDR_DIRECT:    direct_q    <= out_word_t'(acc_i.wdata[$bits(out_word_t)-1:0]);
        ADDR_SEQ_N:     seq_n_q     <= acc_i.wdata[1:0];
        ADDR_SEQ0:      seq_q[0]    <= acc_i.wdata[5:0];
        ADDR_SEQ1:      seq_q[1]    <= acc_i.wdata[5:0];
        ADDR_SEQ2:      seq_q[2]    <= acc_i.wdata[5:0];
        ADDR_SEQ3:      seq_q[3]    <= acc_i.wdata[5:0];  // own slot for step 3
        ADDR_PRECHARGE: precharge_q <= acc_i.wdata[COUNT_W-1:0];
        ADDR_APERTURE:  aperture_q  <= acc_i.wdata[COUNT_W-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read decode, purely combinational on addr

  always_comb begin
    case (acc_i.addr)
      ADDR_MODE:      rdata_o = word_t'(mode_q);
      ADDR_DIRECT:    rdata_o = word_t'(direct_q);
      ADDR_STATUS:    rdata_o = {18'b0, step_i, hw_flags_i, STATUS_MAGIC};
      ADDR_SEQ_N:     rdata_o = word_t'(seq_n_q);
      ADDR_SEQ0:      rdata_o = word_t'(seq_q[0]);
      ADDR_SEQ1:      rdata_o = word_t'(seq_q[1]);
      ADDR_SEQ2:      rdata_o = word_t'(seq_q[2]);
      ADDR_SEQ3:      rdata_o = word_t'(seq_q[3]);
      ADDR_PRECHARGE: rdata_o = word_t'(precharge_q);
      ADDR_APERTURE:  rdata_o = word_t'(aperture_q);
      default:        rdata_o = '0;
    endcase
  end

  assign mode_o          = mode_q;
  assign direct_o        = direct_q;
  assign cfg_o.seq_n     = seq_n_q;
  assign cfg_o.seq       = seq_q;
  assign cfg_o.precharge = count_t'(precharge_q);  // zero extended to max width
  assign cfg_o.aperture  = count_t'(aperture_q);

endmodule

// File: verilog/spi_slave.sv
`timescale 1ns/1ns

module spi_slave import dmm_pkg::*; (
  input  logic        CLK,
  input  logic        reset_i,
  input  logic        sck_i,
  input  logic        ss_i,     // active low
  input  logic        sdi_i,
  output logic        sdo_o,
  output reg_access_t acc_o,
  input  word_t       rdata_i
);

  //////////////////////////////////////////////////
  // pin synchronizers

  logic [2:0] sck_q;  // two sync stages plus one for edge detect
  logic [1:0] ss_q;
  logic [1:0] sdi_q;

  logic sck_rise;
  logic sck_fall;
  logic selected;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign selected = ~ss_q[1];

  //////////////////////////////////////////////////
  // frame state

  logic [5:0] bit_cnt_q;  // rising edges seen in this frame, 0..40
  logic       load_q;     // command byte complete, fetch read data
  logic       strobe_q;
  logic [7:0] cmd_q;      // {write, addr}
  word_t      data_q;     // write data shifted in
  word_t      tx_q;       // read data shifted out

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      sck_q     <= '0;
      ss_q      <= 2'b11;  // deselected
      sdi_q     <= '0;
      bit_cnt_q <= '0;
      load_q    <= 1'b0;
      strobe_q  <= 1'b0;
      tx_q      <= '0;
    end else begin
      sck_q    <= {sck_q[1:0], sck_i};
      ss_q     <= {ss_q[0], ss_i};
      sdi_q    <= {sdi_q[0], sdi_i};
      load_q   <= 1'b0;
      strobe_q <= 1'b0;
      if (!selected) begin
        bit_cnt_q <= '0;  // a partial frame is simply dropped
        tx_q      <= '0;
      end else begin
        if (sck_rise && bit_cnt_q != 6'd40) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == 6'd7) load_q <= 1'b1;    // addr now stable
          if (bit_cnt_q == 6'd39) strobe_q <= 1'b1; // last data bit in
        end
        if (load_q)
          tx_q <= rdata_i;
        else if (sck_fall && bit_cnt_q >= 6'd9 && bit_cnt_q <= 6'd39)
          tx_q <= {tx_q[30:0], 1'b0};  // next bit for the following rising edge
      end
    end
  end

  // payload shift registers
  always_ff @(posedge CLK) begin
    if (selected && sck_rise && bit_cnt_q != 6'd40) begin
      if (bit_cnt_q < 6'd8)
        cmd_q <= {cmd_q[6:0], sdi_q[1]};   // command byte, msb first
      else
        data_q <= {data_q[30:0], sdi_q[1]};
    end
  end

  assign sdo_o        = tx_q[31];
  assign acc_o.strobe = strobe_q;
  assign acc_o.write  = cmd_q[7];
  assign acc_o.addr   = cmd_q[6:0];
  assign acc_o.wdata  = data_q;

endmodule

// File: verilog/dmm_pkg.sv
package dmm_pkg;

  //////////////////////////////////////////////////
  // plain vector types

  typedef logic [31:0] word_t;     // register data word
  typedef logic [6:0]  reg_addr_t; // 7 bit register address
  typedef logic [3:0]  azmux_t;    // az mux switch code
  typedef logic [1:0]  pc_sw_t;    // precharge switch pair
  typedef logic [5:0]  seq_step_t; // {pc_sw, azmux}
  typedef logic [1:0]  step_idx_t; // sequence step index

  localparam int COUNT_W_MAX = 24;         // widest precharge / aperture count
  typedef logic [COUNT_W_MAX-1:0] count_t;

  // mode register, codes 5..7 fall through to all low
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_LO      = 3'd1,
    MODE_HI      = 3'd2,
    MODE_PATTERN = 3'd3,
    MODE_AZ_TEST = 3'd4
  } mode_t;

  //////////////////////////////////////////////////
  // register map

  localparam reg_addr_t ADDR_MODE      = 7'd1;
  localparam reg_addr_t ADDR_DIRECT    = 7'd2;
  localparam reg_addr_t ADDR_STATUS    = 7'd3;  // read only
  localparam reg_addr_t ADDR_SEQ_N     = 7'd4;
  localparam reg_addr_t ADDR_SEQ0      = 7'd5;
  localparam reg_addr_t ADDR_SEQ1      = 7'd6;
  localparam reg_addr_t ADDR_SEQ2      = 7'd7;
  localparam reg_addr_t ADDR_SEQ3      = 7'd8;
  localparam reg_addr_t ADDR_PRECHARGE = 7'd9;
  localparam reg_addr_t ADDR_APERTURE  = 7'd10;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  //////////////////////////////////////////////////
  // bundles

  typedef struct packed {
    logic      strobe;  // one clk per completed frame
    logic      write;
    reg_addr_t addr;
    word_t     wdata;
  } reg_access_t;

  typedef struct packed {
    step_idx_t       seq_n;     // index of last step
    seq_step_t [3:0] seq;
    count_t          precharge;
    count_t          aperture;
  } acq_cfg_t;

  // board output word, leds at the bottom
  typedef struct packed {
    logic       meas_complete;
    azmux_t     azmux;
    pc_sw_t     pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_word_t;

endpackage
